//--- interlockFsm.sv
`default_nettype none

module interlockFsm (
  input  logic clk,
  input  logic reset,
  input  logic fetchMiss,
  input  logic memMiss,
  input  logic memReq,
  input  logic trap,
  input  logic itlbFill,
  input  logic dtlbFill,
  output logic stall,
  output logic walkStart,
  output logic walkSelData,
  output logic ignoreMemReq,
  output logic replay
);

  tlbWalkPkg::interlockState_t state;
  tlbWalkPkg::interlockState_t nextState;
  logic nextIsWalk;

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= tlbWalkPkg::READY;
    end else begin
      state <= nextState;
    end
  end

  // A trap in READY wins over any miss, so the walk never starts
  // When both TLBs miss the data side is walked first, then the fetch
  always_comb begin
    nextState = state;
    case (state)
      tlbWalkPkg::READY: begin
        if (trap) nextState = tlbWalkPkg::READY;
        else if (!fetchMiss && memMiss) nextState = tlbWalkPkg::DTLB_MISS;
        else if (fetchMiss && !memMiss && !memReq) nextState = tlbWalkPkg::ITLB_MISS_ONLY;
        else if (fetchMiss && !memMiss && memReq) nextState = tlbWalkPkg::ITLB_MISS_PENDING;
        else if (fetchMiss && memMiss) nextState = tlbWalkPkg::BOTH_MISS;
        else nextState = tlbWalkPkg::READY;
      end
      // Replay lasts one cycle because there is no cache to stall it
      tlbWalkPkg::REPLAY: nextState = tlbWalkPkg::READY;
      tlbWalkPkg::DTLB_MISS: if (dtlbFill) nextState = tlbWalkPkg::REPLAY;
      // No data request waits here, so the fetch goes straight back to READY
      tlbWalkPkg::ITLB_MISS_ONLY: if (itlbFill) nextState = tlbWalkPkg::READY;
      tlbWalkPkg::ITLB_MISS_PENDING: if (itlbFill) nextState = tlbWalkPkg::REPLAY;
      // Data entry is in, the fetch miss is still outstanding
      tlbWalkPkg::BOTH_MISS: if (dtlbFill) nextState = tlbWalkPkg::ITLB_MISS_PENDING;
      default: nextState = tlbWalkPkg::READY;
    endcase
  end

  ////////////////////
  // Outputs
  ////////////////////

  // Stall is combinational in READY so the missing request is held from its first cycle
  always_comb begin
    case (state)
      tlbWalkPkg::READY: stall = (fetchMiss || memMiss) && !trap;
      tlbWalkPkg::REPLAY: stall = 1'b0;
      default: stall = 1'b1;
    endcase
  end

  assign nextIsWalk = nextState inside {tlbWalkPkg::DTLB_MISS, tlbWalkPkg::ITLB_MISS_ONLY,
                                        tlbWalkPkg::ITLB_MISS_PENDING, tlbWalkPkg::BOTH_MISS};

  // One strobe per walk, also on the step from BOTH_MISS to the fetch walk
  assign walkStart = nextIsWalk && (nextState != state);

  // Tells the walker which VPN to capture in the walkStart cycle
  assign walkSelData = (nextState == tlbWalkPkg::DTLB_MISS) ||
                       (nextState == tlbWalkPkg::BOTH_MISS);

  // The data request must not complete while it misses or while a trap cancels it
  assign ignoreMemReq = ((state == tlbWalkPkg::READY) && (fetchMiss || memMiss || trap)) ||
                        ((state == tlbWalkPkg::REPLAY) && trap);

  assign replay = (nextState == tlbWalkPkg::REPLAY);

  ////////////////////
  // Checks
  ////////////////////

  // The fills are in by the replay cycle, so every held request hits there
  assert property (@(posedge clk) disable iff (reset)
    (state == tlbWalkPkg::REPLAY) |-> !(fetchMiss || memMiss));

  // One walker feeds both TLBs, so only one fill can happen at a time
  assert property (@(posedge clk) disable iff (reset)
    !(itlbFill && dtlbFill));

endmodule

`default_nettype wire

//--- pageTableWalker.sv
`default_nettype none

`include "tlbWalk_macros.svh"

module pageTableWalker (
  input  logic               clk,
  input  logic               reset,
  input  logic               ptWrite,
  input  tlbWalkPkg::vpn_t   ptWriteVpn,
  input  tlbWalkPkg::ppn_t   ptWritePpn,
  input  logic               walkStart,
  input  logic               walkSelData,
  input  tlbWalkPkg::vpn_t   fetchVpn,
  input  tlbWalkPkg::vpn_t   memVpn,
  input  logic               walkDone,
  output logic               itlbFill,
  output logic               dtlbFill,
  output tlbWalkPkg::vpn_t   fillVpn,
  output tlbWalkPkg::ppn_t   fillPpn
);

  localparam int PtDepth = 1 << `VPN_BITS;

  // Direct-mapped page table, one PPN per virtual page
  tlbWalkPkg::ppn_t pageTable [PtDepth];

  // The VPN under walk and the side it belongs to
  tlbWalkPkg::vpn_t walkVpn;
  logic walkIsData;

  ////////////////////
  // Page table
  ////////////////////

  // Every entry is treated as valid, so an all-zero table maps to page 0
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < PtDepth; i++) begin
        pageTable[i] <= '0;
      end
    end else if (ptWrite) begin
      pageTable[ptWriteVpn] <= ptWritePpn;
    end
  end

  ////////////////////
  // Walk capture
  ////////////////////

  // The CPU holds its request during the walk, but the VPN is captured anyway
  always_ff @(posedge clk) begin
    if (walkStart) begin
      walkVpn <= walkSelData ? memVpn : fetchVpn;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      walkIsData <= 1'b0;
    end else if (walkStart) begin
      walkIsData <= walkSelData;
    end
  end

  // The read completes with walkDone and exactly one TLB takes the entry
  assign fillVpn = walkVpn;
  assign fillPpn = pageTable[walkVpn];
  assign itlbFill = walkDone && !walkIsData;
  assign dtlbFill = walkDone && walkIsData;

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks for the pass message
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f tlbWalk.f --top-module tlbWalkTb -o tlbWalkSim

simOutput=$(./obj_dir/tlbWalkSim)
echo "$simOutput"

if grep -q "ALL TESTS PASSED" <<< "$simOutput"; then
  exit 0
else
  exit 1
fi

//--- tlb.sv
`default_nettype none

`include "tlbWalk_macros.svh"

module tlb (
  input  logic             clk,
  input  logic             reset,
  input  tlbWalkPkg::vpn_t lookupVpn,
  input  logic             fill,
  input  tlbWalkPkg::vpn_t fillVpn,
  input  tlbWalkPkg::ppn_t fillPpn,
  output logic             hit,
  output tlbWalkPkg::ppn_t ppn
);

  // Entry storage, only the valid bits are cleared on reset
  logic entryValid [`TLB_ENTRIES];
  tlbWalkPkg::vpn_t entryVpn [`TLB_ENTRIES];
  tlbWalkPkg::ppn_t entryPpn [`TLB_ENTRIES];

  // Next entry to replace
  tlbWalkPkg::tlbIndex_t fillPtr;

  ////////////////////
  // Lookup
  ////////////////////

  // Fully associative match over all entries
  // A VPN is filled only after a miss, so at most one entry matches
  always_comb begin
    hit = 1'b0;
    ppn = '0;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      if (entryValid[i] && (entryVpn[i] == lookupVpn)) begin
        hit = 1'b1;
        ppn = entryPpn[i];
      end
    end
  end

  ////////////////////
  // Fill
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `TLB_ENTRIES; i++) begin
        entryValid[i] <= 1'b0;
      end
      fillPtr <= '0;
    end else if (fill) begin
      entryValid[fillPtr] <= 1'b1;
      // Round robin, the pointer wraps after the last entry
      fillPtr <= fillPtr + 1'b1;
    end
  end

  // Tag and payload follow the valid bit into the same slot
  always_ff @(posedge clk) begin
    if (fill) begin
      entryVpn[fillPtr] <= fillVpn;
      entryPpn[fillPtr] <= fillPpn;
    end
  end

endmodule

`default_nettype wire

//--- tlbWalk.f
+incdir+.
tlbWalkPkg.sv
interlockFsm.sv
walkTimer.sv
pageTableWalker.sv
tlb.sv
tlbWalkTop.sv
tlbWalkTb.sv

//--- tlbWalkPkg.sv
`default_nettype none

`include "tlbWalk_macros.svh"

package tlbWalkPkg;

  // Page numbers on both sides of the translation
  typedef logic [`VPN_BITS-1:0] vpn_t;
  typedef logic [`PPN_BITS-1:0] ppn_t;

  // Points at one TLB entry for replacement
  typedef logic [`TLB_INDEX_BITS-1:0] tlbIndex_t;

  // Value held by the walk timer
  typedef logic [`COUNT_BITS-1:0] walkCount_t;

  // Interlock states, the walk states keep the CPU stalled
  typedef enum logic [2:0] {
    READY,
    REPLAY,
    DTLB_MISS,
    ITLB_MISS_ONLY,
    ITLB_MISS_PENDING,
    BOTH_MISS
  } interlockState_t;

endpackage

`default_nettype wire

//--- tlbWalkTb.sv
`default_nettype none

`include "tlbWalk_macros.svh"

module tlbWalkTb;

  // One stimulus row holds the request levels, the completion cycle counted from
  // presentation, and whether the data side is expected to finish at all
  typedef struct packed {
    logic fetchValid;
    tlbWalkPkg::vpn_t fetchVpn;
    logic memReq;
    tlbWalkPkg::vpn_t memVpn;
    logic trap;
    logic [4:0] expCycles;
    logic expMem;
  } testRow_t;

  localparam int latency = `WALK_LATENCY;
  localparam int ptDepth = 1 << `VPN_BITS;
  // Longest wait for one row, a both-miss plus a spare cycle
  localparam int window = 2 * latency + 2;

  logic clk, reset, ptWrite, fetchValid, memReq, trap;
  tlbWalkPkg::vpn_t ptWriteVpn, fetchVpn, memVpn;
  tlbWalkPkg::ppn_t ptWritePpn, fetchPpn, memPpn;
  logic stall, fetchDone, memDone;

  // Copy of everything written into the page table
  tlbWalkPkg::ppn_t mirror [ptDepth];
  testRow_t rowTable [$];
  integer seed = 32'h2e6a;
  int errorCount = 0;
  int checkCount = 0;
  logic tableReady = 1'b0;

  tlbWalkTop dut_i (.clk, .reset, .ptWrite, .ptWriteVpn, .ptWritePpn, .fetchValid,
                    .fetchVpn, .memReq, .memVpn, .trap, .stall, .fetchDone, .fetchPpn,
                    .memDone, .memPpn);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic flagMismatch(input string name, input int expected, input int actual);
    $display("CHECK FAILED at time %0t: %s expected %0d, got %0d", $time, name, expected,
             actual);
    errorCount++;
  endtask

  task automatic addRow(input logic fv, input int fVpn, input logic mr, input int mVpn,
                        input logic tr, input int cycles, input logic em);
    testRow_t row;
    row.fetchValid = fv;
    row.fetchVpn = tlbWalkPkg::vpn_t'(fVpn);
    row.memReq = mr;
    row.memVpn = tlbWalkPkg::vpn_t'(mVpn);
    row.trap = tr;
    row.expCycles = 5'(cycles);
    row.expMem = em;
    rowTable.push_back(row);
  endtask

  // Random contents, every entry written once through the load strobe
  task automatic loadPageTable();
    int randomWord;
    for (int i = 0; i < ptDepth; i++) begin
      @(negedge clk);
      randomWord = $random(seed);
      ptWrite = 1'b1;
      ptWriteVpn = tlbWalkPkg::vpn_t'(i);
      ptWritePpn = tlbWalkPkg::ppn_t'(randomWord);
      mirror[i] = tlbWalkPkg::ppn_t'(randomWord);
    end
    @(negedge clk);
    ptWrite = 1'b0;
  endtask

  ////////////////////
  // Row execution
  ////////////////////

  // Cycle k = 0 is the presentation cycle, outputs are sampled 1 unit after the drive
  task automatic runRow(input testRow_t row);
    int fetchAt;
    int memAt;
    logic fetchOk;
    logic memOk;
    fetchAt = -1;
    memAt = -1;
    @(negedge clk);
    fetchValid = row.fetchValid;
    fetchVpn = row.fetchVpn;
    memReq = row.memReq;
    memVpn = row.memVpn;
    trap = row.trap;
    for (int k = 0; k <= window; k++) begin
      if (k > 0) @(negedge clk);
      #1;
      checkCount++;
      // The CPU is held only until the expected completion cycle
      if (stall !== (k < int'(row.expCycles)))
        flagMismatch("stall", int'(k < int'(row.expCycles)), int'(stall));
      if (fetchDone === 1'b1 && fetchAt < 0) begin
        fetchAt = k;
        checkCount++;
        if (fetchPpn !== mirror[row.fetchVpn])
          flagMismatch("fetchPpn", int'(mirror[row.fetchVpn]), int'(fetchPpn));
      end
      if (memDone === 1'b1 && !row.expMem)
        flagMismatch("memDone", 0, 1);
      if (memDone === 1'b1 && memAt < 0) begin
        memAt = k;
        checkCount++;
        if (memPpn !== mirror[row.memVpn])
          flagMismatch("memPpn", int'(mirror[row.memVpn]), int'(memPpn));
      end
      fetchOk = !row.fetchValid || (fetchAt >= 0);
      memOk = !row.expMem || (memAt >= 0);
      if (fetchOk && memOk && (row.fetchValid || row.expMem)) break;
    end
    if (row.fetchValid && fetchAt < 0) begin
      $display("Error at time %0t: fetchDone never arrived for fetch page %0d", $time,
               row.fetchVpn);
      errorCount++;
    end else if (row.fetchValid && fetchAt != int'(row.expCycles)) begin
      flagMismatch("fetchDone cycle", int'(row.expCycles), fetchAt);
    end
    if (row.expMem && memAt < 0) begin
      $display("Error at time %0t: memDone never arrived for data page %0d", $time,
               row.memVpn);
      errorCount++;
    end else if (row.expMem && memAt != int'(row.expCycles)) begin
      flagMismatch("memDone cycle", int'(row.expCycles), memAt);
    end
    // Requests drop right after completion, which leaves one idle cycle
    @(negedge clk);
    fetchValid = 1'b0;
    memReq = 1'b0;
    trap = 1'b0;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    reset = 1'b1;
    ptWrite = 1'b0;
    ptWriteVpn = '0;
    ptWritePpn = '0;
    fetchValid = 1'b0;
    fetchVpn = '0;
    memReq = 1'b0;
    memVpn = '0;
    trap = 1'b0;
    // Data-only miss, then the same page hits in the presentation cycle
    addRow(0, 0, 1, 5, 0, latency + 1, 1);
    addRow(0, 0, 1, 5, 0, 0, 1);
    // Fetch-only miss and its hit
    addRow(1, 9, 0, 0, 0, latency + 1, 0);
    addRow(1, 9, 0, 0, 0, 0, 0);
    // Both miss, data walked first, both finish in the replay cycle
    addRow(1, 12, 1, 20, 0, 2 * latency + 1, 1);
    // Trap cancels the walk, so the page still misses afterwards
    addRow(0, 0, 1, 30, 1, 0, 0);
    addRow(0, 0, 1, 30, 0, latency + 1, 1);
    // DTLB now holds 5, 20 and 30 with the pointer at slot 3
    addRow(0, 0, 1, 40, 0, latency + 1, 1);
    addRow(0, 0, 1, 41, 0, latency + 1, 1);
    addRow(0, 0, 1, 42, 0, latency + 1, 1);
    addRow(0, 0, 1, 43, 0, latency + 1, 1);
    // Lands in slot 3 again and evicts page 40
    addRow(0, 0, 1, 44, 0, latency + 1, 1);
    addRow(0, 0, 1, 40, 0, latency + 1, 1);
    addRow(0, 0, 1, 44, 0, 0, 1);
    // Page 43 sits in slot 2, which neither of the last two fills replaced
    addRow(0, 0, 1, 43, 0, 0, 1);
    // Fetch miss while a data hit waits for the replay
    addRow(1, 50, 1, 44, 0, latency + 1, 1);
    tableReady = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    loadPageTable();
    foreach (rowTable[i]) runRow(rowTable[i]);
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table length plus reset and page-table load
  initial begin
    int limit;
    wait (tableReady);
    limit = rowTable.size() * (2 * latency + 6) + ptDepth + 16;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired: the run did not finish within %0d cycles", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tlbWalkTop.sv
`default_nettype none

module tlbWalkTop (
  input  logic             clk,
  input  logic             reset,
  input  logic             ptWrite,
  input  tlbWalkPkg::vpn_t ptWriteVpn,
  input  tlbWalkPkg::ppn_t ptWritePpn,
  input  logic             fetchValid,
  input  tlbWalkPkg::vpn_t fetchVpn,
  input  logic             memReq,
  input  tlbWalkPkg::vpn_t memVpn,
  input  logic             trap,
  output logic             stall,
  output logic             fetchDone,
  output tlbWalkPkg::ppn_t fetchPpn,
  output logic             memDone,
  output tlbWalkPkg::ppn_t memPpn
);

  logic itlbHit, dtlbHit, fetchMiss, memMiss;
  logic walkStart, walkSelData, ignoreMemReq, replay;
  logic walkBusy, walkDone, itlbFill, dtlbFill;
  tlbWalkPkg::vpn_t fillVpn;
  tlbWalkPkg::ppn_t fillPpn;

  // A miss only counts while the request is actually held
  assign fetchMiss = fetchValid && !itlbHit;
  assign memMiss = memReq && !dtlbHit;

  // Requests complete on a hit once the interlock lets them through
  assign fetchDone = fetchValid && itlbHit && !stall;
  assign memDone = memReq && dtlbHit && !stall && !ignoreMemReq;

  interlockFsm fsm_i (.clk, .reset, .fetchMiss, .memMiss, .memReq, .trap, .itlbFill,
                      .dtlbFill, .stall, .walkStart, .walkSelData, .ignoreMemReq, .replay);

  walkTimer timer_i (.clk, .reset, .start(walkStart), .busy(walkBusy), .walkDone);

  pageTableWalker walker_i (.clk, .reset, .ptWrite, .ptWriteVpn, .ptWritePpn, .walkStart,
                            .walkSelData, .fetchVpn, .memVpn, .walkDone, .itlbFill,
                            .dtlbFill, .fillVpn, .fillPpn);

  tlb itlb_i (.clk, .reset, .lookupVpn(fetchVpn), .fill(itlbFill), .fillVpn, .fillPpn,
              .hit(itlbHit), .ppn(fetchPpn));

  tlb dtlb_i (.clk, .reset, .lookupVpn(memVpn), .fill(dtlbFill), .fillVpn, .fillPpn,
              .hit(dtlbHit), .ppn(memPpn));

  // The CPU must see a stall for as long as the page table is being read
  assert property (@(posedge clk) disable iff (reset) walkBusy |-> stall);

  // After the fill the held data request hits and finishes in the replay cycle
  assert property (@(posedge clk) disable iff (reset)
    replay |=> (memDone || trap || !memReq));

endmodule

`default_nettype wire

//--- tlbWalk_macros.svh
`ifndef TLBWALK_MACROS_SVH
`define TLBWALK_MACROS_SVH

// Design-wide sizes for the translation subsystem

// Width of a virtual page number, which also sizes the page table
`define VPN_BITS 6

// Width of a physical page number held in the page table and the TLBs
`define PPN_BITS 8

// Each TLB holds this many fully associative entries
`define TLB_ENTRIES 4

// Pointer width for the round-robin replacement, log2 of the entry count
`define TLB_INDEX_BITS 2

// Cycles taken by one page-table read, counted from the first walk cycle
`define WALK_LATENCY 3

// The walk timer must be wide enough to hold WALK_LATENCY
`define COUNT_BITS 4

`endif

//--- walkTimer.sv
`default_nettype none

`include "tlbWalk_macros.svh"

module walkTimer (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic busy,
  output logic walkDone
);

  tlbWalkPkg::walkCount_t count;

  ////////////////////
  // Latency counter
  ////////////////////

  // Loading the full latency puts walkDone WALK_LATENCY cycles after start
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (start) begin
      count <= tlbWalkPkg::walkCount_t'(`WALK_LATENCY);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign busy = (count != '0);

  // Last cycle of the page-table read, the data is valid now
  assign walkDone = (count == tlbWalkPkg::walkCount_t'(1));

  // A new walk may only start when the previous one finishes in the same cycle,
  // which is the hand-off from the data walk to the fetch walk
  assert property (@(posedge clk) disable iff (reset)
    start |-> (!busy || walkDone));

endmodule

`default_nettype wire
